// File: design/hudPkg.sv
package hudPkg;

    // Screen coordinates of the pixel being drawn
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } pixelPos_t;

    // Player health as the renderer sees it
    typedef struct packed {
        logic [9:0] health;
        logic       godMode;
    } healthInfo_t;

    // Read request into the heart sprite memory
    typedef struct packed {
        logic       hit;
        logic [8:0] addr;
    } spriteTap_t;

    typedef logic [4:0] palIdx_t;

    typedef logic [11:0] rgb_t;

    // Palette slots used by the heart sprites
    localparam palIdx_t palClear   = 5'd0;
    localparam palIdx_t palOutline = 5'd1;
    localparam palIdx_t palFull    = 5'd2;
    localparam palIdx_t palEmpty   = 5'd3;

endpackage

// File: design/healthState.sv
`timescale 1ns/1ps

module healthState #(
    parameter int heartsPerRow = 10,
    parameter int hpPerHeart   = 10
) (
    input  logic               Clk,
    input  logic               rstN,
    input  logic [7:0]         damage,
    input  logic [7:0]         heal,
    input  logic               godToggle,
    output hudPkg::healthInfo_t info,
    output logic               dead
);

    localparam int maxNormal = heartsPerRow * hpPerHeart;
    localparam int maxGod    = 3 * maxNormal;

    localparam logic signed [11:0] limitNormal = 12'(maxNormal);
    localparam logic signed [11:0] limitGod    = 12'(maxGod);

    hudPkg::healthInfo_t state;

    logic                godNext;
    logic signed [11:0]  limit;
    logic signed [11:0]  sum;
    logic [9:0]          healthNext;

    // The ceiling belongs to the mode we end up in, so leaving god mode clamps
    assign godNext = state.godMode ^ godToggle;
    assign limit   = godNext ? limitGod : limitNormal;

    // Zero strobes leave sum equal to the stored health
    assign sum = $signed({2'b00, state.health})
               + $signed({4'b0000, heal})
               - $signed({4'b0000, damage});

    always_comb begin
        if (sum < 0) begin
            healthNext = '0;
        end else if (sum > limit) begin
            healthNext = limit[9:0];
        end else begin
            healthNext = sum[9:0];
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state.health  <= limitNormal[9:0];
            state.godMode <= 1'b0;
        end else begin
            state.health  <= healthNext;
            state.godMode <= godNext;
        end
    end

    assign info = state;
    assign dead = (state.health == '0);

endmodule

// File: design/healthBar.sv
`timescale 1ns/1ps

module healthBar #(
    parameter int heartSize    = 13,
    parameter int heartsPerRow = 10,
    parameter int hpPerHeart   = 10,
    parameter int barX         = 5,
    parameter int barY         = 16
) (
    input  logic                Clk,
    input  logic                rstN,
    input  hudPkg::pixelPos_t   pixel,
    input  hudPkg::healthInfo_t info,
    output hudPkg::spriteTap_t  tap
);

    localparam logic [8:0] sizeW    = 9'(heartSize);
    localparam logic [8:0] spriteSq = 9'(heartSize * heartSize);
    localparam logic [9:0] perRowW  = 10'(heartsPerRow);
    localparam logic [9:0] hpW      = 10'(hpPerHeart);
    localparam logic [8:0] originX  = 9'(barX);
    localparam logic [8:0] originY  = 9'(barY);

    // Bar extents cover one row of hearts or three in god mode
    localparam logic [9:0] xEnd     = 10'(barX + heartsPerRow * heartSize);
    localparam logic [9:0] yEndOne  = 10'(barY + heartSize);
    localparam logic [9:0] yEndGod  = 10'(barY + 3 * heartSize);

    logic [9:0] yEnd;
    logic       inBar;
    logic [8:0] dx;
    logic [8:0] dy;
    logic [8:0] col;
    logic [8:0] row;
    logic [8:0] localX;
    logic [8:0] localY;
    logic [9:0] heartIdx;
    logic [9:0] fullCount;
    logic       isFull;
    logic [8:0] addr;

    assign yEnd = info.godMode ? yEndGod : yEndOne;

    assign inBar = (pixel.x >= originX) && ({1'b0, pixel.x} < xEnd)
                && (pixel.y >= originY) && ({1'b0, pixel.y} < yEnd);

    assign dx = pixel.x - originX;
    assign dy = pixel.y - originY;

    // Which heart we are in, and where inside its sprite
    assign col    = dx / sizeW;
    assign row    = dy / sizeW;
    assign localX = dx % sizeW;
    assign localY = dy % sizeW;

    assign heartIdx  = 10'(row) * perRowW + 10'(col);
    assign fullCount = info.health / hpW;
    assign isFull    = heartIdx < fullCount;

    always_comb begin
        addr = '0;
        if (inBar) begin
            addr = localY * sizeW + localX;
            // Empty heart image sits right after the full one
            if (!isFull) begin
                addr = addr + spriteSq;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            tap <= '0;
        end else begin
            tap.hit  <= inBar;
            tap.addr <= addr;
        end
    end

endmodule

// File: design/heartRom.sv
`timescale 1ns/1ps

module heartRom #(
    parameter int heartSize = 13
) (
    input  logic               Clk,
    input  logic               rstN,
    input  hudPkg::spriteTap_t tap,
    output logic               hit,
    output hudPkg::palIdx_t    idx
);

    localparam logic [8:0] sizeW    = 9'(heartSize);
    localparam logic [8:0] lastPix  = 9'(heartSize - 1);
    localparam logic [8:0] spriteSq = 9'(heartSize * heartSize);

    logic            emptyImg;
    logic [8:0]      rel;
    logic [8:0]      localX;
    logic [8:0]      localY;
    logic            edgeX;
    logic            edgeY;
    hudPkg::palIdx_t pixIdx;

    // Two images sit back to back with the full one first
    assign emptyImg = tap.addr >= spriteSq;
    assign rel      = emptyImg ? tap.addr - spriteSq : tap.addr;
    assign localY   = rel / sizeW;
    assign localX   = rel % sizeW;

    assign edgeX = (localX == '0) || (localX == lastPix);
    assign edgeY = (localY == '0) || (localY == lastPix);

    always_comb begin
        if (edgeX && edgeY) begin
            pixIdx = hudPkg::palClear;
        end else if (edgeX || edgeY) begin
            pixIdx = hudPkg::palOutline;
        end else if (emptyImg) begin
            pixIdx = hudPkg::palEmpty;
        end else begin
            pixIdx = hudPkg::palFull;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            hit <= 1'b0;
            idx <= hudPkg::palClear;
        end else begin
            hit <= tap.hit;
            idx <= pixIdx;
        end
    end

endmodule

// File: design/paletteLut.sv
`timescale 1ns/1ps

module paletteLut (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            hit,
    input  hudPkg::palIdx_t idx,
    output logic            hudOn,
    output hudPkg::rgb_t    rgb
);

    hudPkg::rgb_t colourTable [32];
    logic         visible;

    // Unused slots are magenta so a stray index shows up on screen
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            colourTable[i] = 12'hF0F;
        end
        colourTable[hudPkg::palClear]   = 12'h000;
        colourTable[hudPkg::palOutline] = 12'h000;
        colourTable[hudPkg::palFull]    = 12'hF00;
        colourTable[hudPkg::palEmpty]   = 12'h555;
    end

    assign visible = hit && (idx != hudPkg::palClear);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            hudOn <= 1'b0;
            rgb   <= '0;
        end else begin
            hudOn <= visible;
            rgb   <= visible ? colourTable[idx] : '0;
        end
    end

endmodule

// File: design/hudTop.sv
`timescale 1ns/1ps

module hudTop #(
    parameter int heartSize    = 13,
    parameter int heartsPerRow = 10,
    parameter int hpPerHeart   = 10,
    parameter int barX         = 5,
    parameter int barY         = 16
) (
    input  logic              Clk,
    input  logic              rstN,
    input  hudPkg::pixelPos_t pixel,
    input  logic [7:0]        damage,
    input  logic [7:0]        heal,
    input  logic              godToggle,
    output logic              hudOn,
    output hudPkg::rgb_t      rgb,
    output logic              dead
);

    hudPkg::healthInfo_t info;
    hudPkg::spriteTap_t  tap;
    logic                romHit;
    hudPkg::palIdx_t     romIdx;

    healthState #(
        .heartsPerRow (heartsPerRow),
        .hpPerHeart   (hpPerHeart)
    ) u_healthState (
        .Clk       (Clk),
        .rstN      (rstN),
        .damage    (damage),
        .heal      (heal),
        .godToggle (godToggle),
        .info      (info),
        .dead      (dead)
    );

    // The pixel path runs through hit test, sprite lookup and colour in three stages
    healthBar #(
        .heartSize    (heartSize),
        .heartsPerRow (heartsPerRow),
        .hpPerHeart   (hpPerHeart),
        .barX         (barX),
        .barY         (barY)
    ) u_healthBar (
        .Clk   (Clk),
        .rstN  (rstN),
        .pixel (pixel),
        .info  (info),
        .tap   (tap)
    );

    heartRom #(
        .heartSize (heartSize)
    ) u_heartRom (
        .Clk  (Clk),
        .rstN (rstN),
        .tap  (tap),
        .hit  (romHit),
        .idx  (romIdx)
    );

    paletteLut u_paletteLut (
        .Clk   (Clk),
        .rstN  (rstN),
        .hit   (romHit),
        .idx   (romIdx),
        .hudOn (hudOn),
        .rgb   (rgb)
    );

endmodule

// File: dv/hudTb.sv
`timescale 1ns/1ps

module hudTb;

    localparam int    clkPeriodNs = 100;
    localparam int    normalMax   = 100;
    localparam string vectorFile  = "dv/hudVectors.txt";

    // One line of the vector file
    typedef struct packed {
        logic [7:0]        damage;
        logic [7:0]        heal;
        logic              godToggle;
        hudPkg::pixelPos_t pixel;
        logic              hudOn;
        hudPkg::rgb_t      rgb;
    } vector_t;

    // Output expected three cycles after its pixel went in
    typedef struct packed {
        logic [15:0]  vecLine;
        logic         hudOn;
        hudPkg::rgb_t rgb;
    } expect_t;

    logic              Clk = 1'b0;
    logic              rstN;
    hudPkg::pixelPos_t pixel;
    logic [7:0]        damage;
    logic [7:0]        heal;
    logic              godToggle;
    logic              hudOn;
    hudPkg::rgb_t      rgb;
    logic              dead;

    vector_t vectors[$];
    expect_t pending[$];
    int      errors;
    int      checks;
    bit      loaded;
    int      modelHealth;
    bit      modelGod;

    hudTop u_dut (
        .Clk       (Clk),
        .rstN      (rstN),
        .pixel     (pixel),
        .damage    (damage),
        .heal      (heal),
        .godToggle (godToggle),
        .hudOn     (hudOn),
        .rgb       (rgb),
        .dead      (dead)
    );

    always #(clkPeriodNs / 2) Clk = ~Clk;

    task automatic driveIdle();
        pixel     = '0;
        damage    = '0;
        heal      = '0;
        godToggle = 1'b0;
    endtask

    task automatic loadVectors(output bit ok);
        int      fd;
        int      count;
        int      lineNo;
        string   text;
        int      d;
        int      h;
        int      g;
        int      x;
        int      y;
        int      on;
        int      c;
        vector_t v;
        ok = 1'b0;
        fd = $fopen(vectorFile, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", vectorFile);
            return;
        end
        lineNo = 0;
        while (!$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) == 0) begin
                break;
            end
            lineNo++;
            // Blank lines and comment lines carry no vector
            if (text.len() < 2 || text.getc(0) == "/") begin
                continue;
            end
            count = $sscanf(text, "%h %h %h %h %h %h %h", d, h, g, x, y, on, c);
            if (count != 7) begin
                $display("Vector line %0d has %0d fields instead of 7", lineNo, count);
                errors++;
                continue;
            end
            v.damage    = 8'(d);
            v.heal      = 8'(h);
            v.godToggle = 1'(g);
            v.pixel.x   = 9'(x);
            v.pixel.y   = 9'(y);
            v.hudOn     = 1'(on);
            v.rgb       = 12'(c);
            vectors.push_back(v);
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    task automatic resetDut();
        rstN = 1'b0;
        repeat (5) @(posedge Clk);
        #1;
        rstN = 1'b1;
    endtask

    // Health takes the net change of the strobes, saturates and is clamped when god mode ends
    task automatic updateHealthModel(input vector_t v);
        int ceiling;
        int next;
        if (v.godToggle) begin
            modelGod = !modelGod;
        end
        ceiling = modelGod ? 3 * normalMax : normalMax;
        next = modelHealth + int'(v.heal) - int'(v.damage);
        if (next < 0) begin
            next = 0;
        end else if (next > ceiling) begin
            next = ceiling;
        end
        modelHealth = next;
    endtask

    task automatic checkOutputs();
        expect_t want;
        bit      wantDead;
        want     = pending.pop_front();
        wantDead = (modelHealth == 0);
        checks++;
        assert (hudOn === want.hudOn && rgb === want.rgb) else begin
            errors++;
            $display("[FAIL] %0t: vector %0d gave hudOn=%b rgb=%h, expected hudOn=%b rgb=%h",
                     $realtime, want.vecLine, hudOn, rgb, want.hudOn, want.rgb);
        end
        checks++;
        assert (dead === wantDead) else begin
            errors++;
            $display("[FAIL] %0t: dead=%b, expected %b at health %0d",
                     $realtime, dead, wantDead, modelHealth);
        end
    endtask

    task automatic applyVector(input vector_t v, input int index);
        expect_t want;
        pixel         = v.pixel;
        damage        = v.damage;
        heal          = v.heal;
        godToggle     = v.godToggle;
        want.vecLine  = 16'(index + 1);
        want.hudOn    = v.hudOn;
        want.rgb      = v.rgb;
        pending.push_back(want);
        updateHealthModel(v);
    endtask

    task automatic runVectors();
        expect_t idle;
        idle.vecLine = '0;
        idle.hudOn   = 1'b0;
        idle.rgb     = '0;
        // The pipeline is still clear for the first three cycles
        repeat (3) pending.push_back(idle);
        foreach (vectors[i]) begin
            @(posedge Clk);
            #1;
            checkOutputs();
            applyVector(vectors[i], i);
        end
        repeat (3) begin
            @(posedge Clk);
            #1;
            checkOutputs();
            driveIdle();
        end
    endtask

    initial begin : mainFlow
        bit ok;
        $timeformat(-9, 0, " ns", 0);
        errors      = 0;
        checks      = 0;
        loaded      = 1'b0;
        modelHealth = normalMax;
        modelGod    = 1'b0;
        rstN        = 1'b0;
        driveIdle();
        loadVectors(ok);
        if (ok) begin
            loaded = 1'b1;
            resetDut();
            runVectors();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (ok && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limitNs;
        wait (loaded);
        limitNs = (vectors.size() + 20) * clkPeriodNs;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: dv/hudVectors.txt
// damage heal godToggle pixelX pixelY expHudOn expRgb, all hex, one cycle per line
// Expected outputs use the health before the strobes of the same line
00 00 0 000 000 0 000
00 00 0 005 010 0 000
00 00 0 00b 016 1 f00
00 00 0 018 016 1 f00
00 00 0 025 016 1 f00
00 00 0 032 016 1 f00
00 00 0 03f 016 1 f00
00 00 0 04c 016 1 f00
00 00 0 059 016 1 f00
00 00 0 066 016 1 f00
00 00 0 073 016 1 f00
00 00 0 080 016 1 f00
00 00 0 005 016 1 000
00 00 0 080 010 1 000
00 00 0 086 016 1 000
00 00 0 087 016 0 000
00 00 0 00b 023 0 000
00 00 0 00b 030 0 000
23 00 0 000 000 0 000
00 00 0 00b 016 1 f00
00 00 0 04c 016 1 f00
00 00 0 059 016 1 555
00 00 0 080 016 1 555
00 14 0 000 000 0 000
00 00 0 066 016 1 f00
00 00 0 073 016 1 555
00 00 0 06d 016 1 000
00 00 1 000 000 0 000
00 00 0 00b 023 1 555
00 fa 0 000 000 0 000
00 00 0 080 016 1 f00
00 00 0 00b 023 1 f00
00 00 0 080 030 1 f00
00 00 0 04c 030 1 f00
00 00 0 005 02a 0 000
00 00 0 00b 03d 0 000
00 00 1 000 000 0 000
00 00 0 00b 023 0 000
00 00 0 080 016 1 f00
00 00 0 080 030 0 000
ff 00 0 000 000 0 000
ff 00 0 000 000 0 000
00 00 0 00b 016 1 555
00 00 0 080 016 1 555
00 00 0 005 016 1 000

// File: build.f
design/hudPkg.sv
design/healthState.sv
design/healthBar.sv
design/heartRom.sv
design/paletteLut.sv
design/hudTop.sv
dv/hudTb.sv

// File: Makefile
# Verilator flow for the health overlay testbench

TOP := hudTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || { echo "Pass message missing from log"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
